// File: rtl/lsu_pkg.sv
// ====================
// lsu package: widths, buffer bases, opcodes
// and the per-opcode phase count
// ====================
package lsu_pkg;

    localparam int data_w    = 32;                  // stack word
    localparam int addr_w    = 12;                  // 4 KiB byte space
    localparam int byte_w    = 8;
    localparam int mem_depth = 1 << addr_w;         // bytes in memory

    typedef logic [data_w-1:0] data_t;              // TOS / NOS word
    typedef logic [addr_w-1:0] addr_t;              // byte address
    typedef logic [byte_w-1:0] byte_t;              // memory byte
    typedef logic [2:0]        phase_t;             // phase 0..4
    typedef logic [1:0]        bsel_t;              // 0 = msb byte

    localparam addr_t tib_base  = 12'h800;          // input buffer start
    localparam addr_t obuf_base = 12'hC00;          // output buffer start

    typedef enum logic [3:0] {
        op_nop     = 4'd0,
        op_iaload  = 4'd1,
        op_baload  = 4'd2,
        op_saload  = 4'd3,
        op_iastore = 4'd4,
        op_bastore = 4'd5,
        op_sastore = 4'd6,
        op_get     = 4'd7,
        op_put     = 4'd8
    } opcode_t;

    typedef enum logic [1:0] {
        idle   = 2'd0,                              // waiting for a strobe
        run    = 2'd1,                              // stepping phases
        finish = 2'd2                               // done cycle
    } seq_state_t;

    // final phase of each operation
    function automatic phase_t last_phase(input opcode_t op);
        case (op)
            op_iaload, op_iastore:            return 3'd4;
            op_saload, op_sastore:            return 3'd2;
            op_baload, op_bastore,
            op_get, op_put:                   return 3'd1;
            default:                          return 3'd0;  // nop
        endcase
    endfunction

endpackage

// File: rtl/byte_ram.sv
// ====================
// byte ram: 4 KiB, async read, sync write
// ====================
module byte_ram (
    input  logic           ctl,
    input  lsu_pkg::addr_t addr,
    input  logic           we,
    input  lsu_pkg::byte_t wdata,
    output lsu_pkg::byte_t rdata
);
    import lsu_pkg::*;

    byte_t mem [mem_depth];                         // contents unknown until written

    always_ff @(posedge ctl) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];                       // same-cycle read

endmodule

// File: rtl/lsu_sequencer.sv
// ====================
// lsu sequencer: accepts one operation, steps
// its phases and signals busy, start and done
// ====================
module lsu_sequencer (
    input  logic             ctl,
    input  logic             rst_n,
    input  logic             op_valid,
    input  lsu_pkg::opcode_t op,
    output logic             busy,
    output logic             start,
    output logic             done,
    output lsu_pkg::opcode_t cur_op,
    output lsu_pkg::phase_t  phase
);
    import lsu_pkg::*;

    seq_state_t state;                              // fsm state
    logic       accept;                             // strobe taken this edge
    logic       last;                               // final phase reached

    assign accept = op_valid && !busy;              // strobes while busy dropped
    assign last   = (phase == last_phase(cur_op));

    assign busy = (state == run);
    assign done = (state == finish);                // one cycle after last phase

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            state  <= idle;
            phase  <= '0;
            cur_op <= op_nop;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;                          // single-cycle pulse
            case (state)
                idle, finish: begin
                    // a new op may arrive in the done cycle
                    if (accept) begin
                        state  <= run;
                        cur_op <= op;               // latch opcode
                        phase  <= '0;
                        start  <= 1'b1;             // unit captures operands
                    end else begin
                        state <= idle;
                    end
                end
                run: begin
                    if (last) begin
                        state <= finish;            // busy drops, done rises
                    end else begin
                        phase <= phase + 3'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: rtl/load_store_unit.sv
// ====================
// load/store unit: per-phase byte moves between
// the stack registers and byte-wide memory
// ====================
module load_store_unit (
    input  logic             ctl,
    input  logic             rst_n,
    input  logic             start,
    input  logic             busy,
    input  lsu_pkg::opcode_t cur_op,
    input  lsu_pkg::phase_t  phase,
    input  lsu_pkg::data_t   tos_in,
    input  lsu_pkg::data_t   nos_in,
    input  lsu_pkg::byte_t   mem_rdata,
    output lsu_pkg::addr_t   mem_addr,
    output logic             mem_we,
    output lsu_pkg::byte_t   mem_wdata,
    output lsu_pkg::data_t   tos,
    output lsu_pkg::addr_t   in_ptr,
    output lsu_pkg::addr_t   out_ptr
);
    import lsu_pkg::*;

    // registers
    addr_t addr;                                    // memory address
    data_t nos;                                     // captured NOS
    bsel_t bsel;                                    // write byte select

    // next values and their enables
    data_t tos_n;
    logic  tos_x;
    addr_t addr_n;
    logic  addr_x;
    bsel_t bsel_n;
    logic  bsel_x;
    logic  we;                                      // write this phase
    logic  in_x, out_x;                             // buffer pointer steps

    // wires
    data_t tos_cur;                                 // operands valid in phase 0
    data_t nos_cur;
    data_t t_sext;                                  // sign-extended read byte
    data_t t_merge;                                 // shift left, merge byte

    assign tos_cur = start ? tos_in : tos;          // registers load at end of start
    assign nos_cur = start ? nos_in : nos;
    assign t_sext  = {{24{mem_rdata[7]}}, mem_rdata};
    assign t_merge = {tos[23:0], mem_rdata};

    // small per-phase actions
    task automatic set_tos(input data_t d);
        tos_n = d;
        tos_x = 1'b1;
    endtask

    task automatic set_addr(input addr_t a);
        addr_n = a;
        addr_x = 1'b1;
    endtask

    task automatic set_bsel(input bsel_t b);
        bsel_n = b;
        bsel_x = 1'b1;
    endtask

    // write selected byte, then step address and select
    task automatic write_step();
        we = 1'b1;
        set_addr(addr + 12'd1);
        set_bsel(bsel + 2'd1);
    endtask

    always_comb begin
        tos_n  = '0;
        tos_x  = 1'b0;
        addr_n = '0;
        addr_x = 1'b0;
        bsel_n = 2'd3;
        bsel_x = 1'b0;
        we     = 1'b0;
        in_x   = 1'b0;
        out_x  = 1'b0;
        case (cur_op)
            op_iaload:
                case (phase)
                    3'd0: set_addr(tos_cur[11:0]);
                    3'd1: begin set_addr(addr + 12'd1); set_tos(t_sext); end
                    3'd2, 3'd3: begin set_addr(addr + 12'd1); set_tos(t_merge); end
                    3'd4: set_tos(t_merge);
                    default: ;
                endcase
            op_baload:
                case (phase)
                    3'd0: set_addr(tos_cur[11:0]);
                    3'd1: set_tos(t_sext);          // signed byte
                    default: ;
                endcase
            op_saload:
                case (phase)
                    3'd0: set_addr(tos_cur[11:0]);
                    3'd1: begin set_addr(addr + 12'd1); set_tos(t_sext); end
                    3'd2: set_tos(t_merge);
                    default: ;
                endcase
            op_iastore:
                case (phase)
                    3'd0: begin set_addr(nos_cur[11:0]); set_bsel(2'd0); end
                    3'd1, 3'd2, 3'd3: write_step();
                    3'd4: we = 1'b1;                // lsb, no further step
                    default: ;
                endcase
            op_bastore:
                case (phase)
                    3'd0: begin set_addr(nos_cur[11:0]); set_bsel(2'd3); end
                    3'd1: we = 1'b1;
                    default: ;
                endcase
            op_sastore:
                case (phase)
                    3'd0: begin set_addr(nos_cur[11:0]); set_bsel(2'd2); end
                    3'd1: write_step();
                    3'd2: we = 1'b1;
                    default: ;
                endcase
            op_get:
                case (phase)
                    3'd0: set_addr(in_ptr);
                    3'd1: begin set_tos(t_sext); in_x = 1'b1; end
                    default: ;
                endcase
            op_put:
                case (phase)
                    3'd0: begin set_addr(out_ptr); set_bsel(2'd3); end
                    3'd1: begin we = 1'b1; out_x = 1'b1; end
                    default: ;
                endcase
            default: ;                              // nop moves nothing
        endcase
    end

    // byte mux, msb first
    always_comb begin
        case (bsel)
            2'd0:    mem_wdata = tos[31:24];
            2'd1:    mem_wdata = tos[23:16];
            2'd2:    mem_wdata = tos[15:8];
            default: mem_wdata = tos[7:0];
        endcase
    end

    assign mem_addr = addr;
    assign mem_we   = we && busy;                   // no writes between ops

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            addr    <= '0;
            tos     <= '0;
            nos     <= '0;
            bsel    <= 2'd3;
            in_ptr  <= tib_base;
            out_ptr <= obuf_base;
        end else if (busy) begin
            if (start) begin
                tos <= tos_in;                      // operand capture
                nos <= nos_in;
            end
            if (tos_x)  tos     <= tos_n;
            if (addr_x) addr    <= addr_n;
            if (bsel_x) bsel    <= bsel_n;
            if (in_x)   in_ptr  <= in_ptr + 12'd1;
            if (out_x)  out_ptr <= out_ptr + 12'd1;
        end
    end

endmodule

// File: rtl/lsu_top.sv
// ====================
// lsu top: sequencer, load/store unit, memory
// ====================
module lsu_top (
    input  logic             ctl,
    input  logic             rst_n,
    input  logic             op_valid,
    input  lsu_pkg::opcode_t op,
    input  lsu_pkg::data_t   tos_in,
    input  lsu_pkg::data_t   nos_in,
    output logic             busy,
    output logic             done,
    output lsu_pkg::data_t   tos_out,
    output lsu_pkg::addr_t   in_ptr,
    output lsu_pkg::addr_t   out_ptr
);
    import lsu_pkg::*;

    logic    start;                                 // first cycle of a run
    opcode_t cur_op;                                // latched opcode
    phase_t  phase;
    addr_t   mem_addr;
    logic    mem_we;
    byte_t   mem_wdata;
    byte_t   mem_rdata;

    lsu_sequencer sequencer_inst (
        .ctl      (ctl),
        .rst_n    (rst_n),
        .op_valid (op_valid),
        .op       (op),
        .busy     (busy),
        .start    (start),
        .done     (done),
        .cur_op   (cur_op),
        .phase    (phase)
    );

    load_store_unit lsu_inst (
        .ctl       (ctl),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .cur_op    (cur_op),
        .phase     (phase),
        .tos_in    (tos_in),
        .nos_in    (nos_in),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .tos       (tos_out),
        .in_ptr    (in_ptr),
        .out_ptr   (out_ptr)
    );

    byte_ram ram_inst (
        .ctl   (ctl),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// File: tests/lsu_top_asserts.sv
// ====================
// lsu assertions check the done pulse, busy
// and write enable rules and reset outputs
// ====================
module lsu_top_asserts (
    input logic ctl,
    input logic rst_n,
    input logic busy,
    input logic start,
    input logic done,
    input logic mem_we
);
    timeunit 1ns;
    timeprecision 100ps;

    done_single_pulse: assert property (@(posedge ctl) disable iff (!rst_n)
        done |=> !done)                                 // one-cycle pulse
        else $error("done high two cycles in a row");

    done_at_busy_fall: assert property (@(posedge ctl) disable iff (!rst_n)
        done == $fell(busy))                            // done closes every run
        else $error("done does not match the end of a run");

    we_byte_phases: assert property (@(posedge ctl) disable iff (!rst_n)
        mem_we |-> (busy && !start))                    // never in operand capture
        else $error("memory write outside the byte phases of a run");

    quiet_in_reset: assert property (@(posedge ctl)
        !rst_n |-> (!busy && !done))
        else $error("busy or done high during reset");

endmodule

bind lsu_top lsu_top_asserts asserts_inst (
    .ctl    (ctl),
    .rst_n  (rst_n),
    .busy   (busy),
    .start  (start),
    .done   (done),
    .mem_we (mem_we)
);

// File: tests/lsu_top_tb.sv
// ====================
// lsu testbench drives stimulus vectors into
// lsu_top and checks results, pointers and latency
// ====================
module lsu_top_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int max_vec = 64;                        // vector table size

    logic    ctl;
    logic    rst_n;
    logic    op_valid;
    opcode_t op;
    data_t   tos_in;
    data_t   nos_in;
    logic    busy;
    logic    done;
    data_t   tos_out;
    addr_t   in_ptr;
    addr_t   out_ptr;

    int          vec_id  [max_vec];                     // test numbers
    logic [3:0]  vec_op  [max_vec];
    data_t       vec_tos [max_vec];
    data_t       vec_nos [max_vec];
    data_t       vec_exp [max_vec];                     // expected tos_out
    int          num_vec    = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_errs  = 0;                        // mismatches in current test
    bit          loaded     = 1'b0;
    int          cycle_count;
    addr_t       exp_in_ptr;                            // pointer model
    addr_t       exp_out_ptr;

    lsu_top lsu_top_inst (
        .ctl      (ctl),
        .rst_n    (rst_n),
        .op_valid (op_valid),
        .op       (op),
        .tos_in   (tos_in),
        .nos_in   (nos_in),
        .busy     (busy),
        .done     (done),
        .tos_out  (tos_out),
        .in_ptr   (in_ptr),
        .out_ptr  (out_ptr)
    );

    initial begin
        ctl = 1'b0;
        forever #20 ctl = ~ctl;                         // 40 ns period
    end

    // cycles from accepting edge to done, incl. the done cycle
    function automatic int expected_cycles(input opcode_t code);
        case (code)
            op_iaload, op_iastore:            return 6;  // four byte phases
            op_saload, op_sastore:            return 4;
            op_baload, op_bastore,
            op_get, op_put:                   return 3;
            default:                          return 2;  // nop runs phase 0 only
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h got %h", name, expected, actual);
            test_errs++;
        end
    endtask

    // drive one vector on the falling edge and wait for done
    task automatic run_test(input int i);
        opcode_t code;
        int      cycles;
        code      = opcode_t'(vec_op[i]);
        cycles    = 0;
        test_errs = 0;
        op        = code;
        tos_in    = vec_tos[i];
        nos_in    = vec_nos[i];
        op_valid  = 1'b1;                               // one-cycle strobe
        do begin
            @(negedge ctl);
            cycles++;
            op_valid = 1'b0;
            if (cycles == 2 && expected_cycles(code) > 2) begin
                op_valid = 1'b1;                        // stray strobe while busy
                op       = op_iastore;
            end
            if (!done) begin
                check_value("busy", 1'b1, busy);        // high through the run
            end
        end while (!done);
        if (code == op_get) exp_in_ptr++;
        if (code == op_put) exp_out_ptr++;
        check_value("busy", 1'b0, busy);                // low in the done cycle
        check_value("cycles", expected_cycles(code), cycles);
        check_value("tos_out", vec_exp[i], tos_out);
        check_value("in_ptr", exp_in_ptr, in_ptr);
        check_value("out_ptr", exp_out_ptr, out_ptr);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %0d op %0d: pass", vec_id[i], vec_op[i]);
        end else begin
            fail_count++;
            $display("test %0d op %0d: fail", vec_id[i], vec_op[i]);
        end
    endtask

    initial begin
        int          fd;
        string       line;
        int          id;
        logic [31:0] c;
        logic [31:0] t;
        logic [31:0] n;
        logic [31:0] e;
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op       = op_nop;
        tos_in   = '0;
        nos_in   = '0;
        fd = $fopen("tests/lsu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
        end else begin
            while (!$feof(fd) && num_vec < max_vec) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines do not scan
                if ($sscanf(line, "%d %h %h %h %h", id, c, t, n, e) == 5) begin
                    vec_id[num_vec]  = id;
                    vec_op[num_vec]  = c[3:0];
                    vec_tos[num_vec] = t;
                    vec_nos[num_vec] = n;
                    vec_exp[num_vec] = e;
                    num_vec++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (4) @(negedge ctl);                      // reset for 4 cycles
        rst_n = 1'b1;
        @(negedge ctl);
        exp_in_ptr  = tib_base;
        exp_out_ptr = obuf_base;
        for (int i = 0; i < num_vec; i++) begin
            run_test(i);
        end
        if (num_vec == 0) begin
            $display("no test vectors were read");
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && num_vec > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // at most 8 cycles per vector plus reset margin
    initial begin
        cycle_count = 0;
        wait (loaded);
        while (cycle_count < num_vec * 8 + 20) begin
            @(posedge ctl);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: vlog.f
rtl/lsu_pkg.sv
rtl/byte_ram.sv
rtl/lsu_sequencer.sv
rtl/load_store_unit.sv
rtl/lsu_top.sv
tests/lsu_top_asserts.sv
tests/lsu_top_tb.sv

// File: tests/lsu_stimulus.txt
// test  opcode  tos(hex)  nos(hex)  expected tos_out(hex)
// opcodes: 0 nop 1 iaload 2 baload 3 saload 4 iastore 5 bastore 6 sastore 7 get 8 put
1  4 81234567 0000000A 81234567
2  1 0000000A 00000000 81234567
3  5 123456F0 00000020 123456F0
4  6 00007FFE 00000030 00007FFE
5  2 00000020 00000000 FFFFFFF0
6  3 00000030 00000000 00007FFE
7  6 00008001 00000034 00008001
8  3 00000034 00000000 FFFF8001
9  4 9C3AE57F 00000040 9C3AE57F
10 2 00000040 00000000 FFFFFF9C
11 2 00000041 00000000 0000003A
12 2 00000042 00000000 FFFFFFE5
13 2 00000043 00000000 0000007F
14 5 00000048 00000800 00000048
15 5 000000C9 00000801 000000C9
16 7 DEADBEEF 00000000 00000048
17 7 DEADBEEF 00000000 FFFFFFC9
18 8 00000041 00000000 00000041
19 8 00000042 00000000 00000042
20 2 00000C00 00000000 00000041
21 2 00000C01 00000000 00000042
22 0 12345678 00000000 12345678
